// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and pc width
`define RV_XLEN 32

// rv32e register file, upper bit of each register field ignored
`define RV_REG_AW 4
`define RV_NUM_REGS 16

`endif

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // major opcodes handled by this slice
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  // alu ops follow {funct7[5], funct3} where that fits
  // branch compares fill the free codes
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SLL  = 4'h1,
    ALU_SLT  = 4'h2,
    ALU_SLTU = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SRL  = 4'h5,
    ALU_OR   = 4'h6,
    ALU_AND  = 4'h7,
    ALU_SUB  = 4'h8,
    ALU_BEQ  = 4'h9,
    ALU_BNE  = 4'ha,
    ALU_BLT  = 4'hb,
    ALU_BGE  = 4'hc,
    ALU_SRA  = 4'hd,
    ALU_BLTU = 4'he,
    ALU_BGEU = 4'hf
  } alu_op_e;

endpackage

`default_nettype wire

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_REG_AW-1:0] rs1_i,
  input  logic [`RV_REG_AW-1:0] rs2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  output logic                  busy1_o,
  output logic                  busy2_o,
  input  logic                  issue_en_i,
  input  logic [`RV_REG_AW-1:0] issue_rd_i,
  input  logic                  wr_en_i,
  input  logic [`RV_REG_AW-1:0] wr_rd_i,
  input  logic [`RV_XLEN-1:0]   wr_data_i
);

  logic [`RV_XLEN-1:0]     regs [`RV_NUM_REGS];
  // scoreboard with one bit per register that has a write in flight
  logic [`RV_NUM_REGS-1:0] busy;
  logic                    wr_hit1;
  logic                    wr_hit2;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      busy <= '0;
    end else begin
      // x0 is never written and never busy
      if (wr_en_i && wr_rd_i != '0) begin
        regs[wr_rd_i] <= wr_data_i;
        busy[wr_rd_i] <= 1'b0;
      end
      // later assignment so a set beats a clear on the same register
      if (issue_en_i && issue_rd_i != '0) begin
        busy[issue_rd_i] <= 1'b1;
      end
    end
  end

  // retiring write seen by the reads in its own cycle
  assign wr_hit1  = wr_en_i && wr_rd_i != '0 && wr_rd_i == rs1_i;
  assign wr_hit2  = wr_en_i && wr_rd_i != '0 && wr_rd_i == rs2_i;

  assign rdata1_o = wr_hit1 ? wr_data_i : regs[rs1_i];
  assign rdata2_o = wr_hit2 ? wr_data_i : regs[rs2_i];
  assign busy1_o  = busy[rs1_i] && !wr_hit1;
  assign busy2_o  = busy[rs2_i] && !wr_hit2;

endmodule

`default_nettype wire

// ==== hdl/rv_idu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_idu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  input  logic                  busy1_i,
  input  logic                  busy2_i,
  input  logic                  fwd_valid_i,
  input  logic [`RV_REG_AW-1:0] fwd_rd_i,
  input  logic [`RV_XLEN-1:0]   fwd_data_i,
  output logic                  issue_en_o,
  output logic [`RV_REG_AW-1:0] issue_rd_o,
  output logic                  id_valid_o,
  input  logic                  ex_ready_i,
  output rv_pkg::alu_op_e       alu_op_o,
  output logic [`RV_XLEN-1:0]   op1_o,
  output logic [`RV_XLEN-1:0]   op2_o,
  output logic                  link_o,
  output logic [`RV_XLEN-1:0]   link_value_o,
  output logic [`RV_XLEN-1:0]   br_target_o,
  output logic [`RV_REG_AW-1:0] rd_o,
  output logic                  wen_o,
  output logic                  illegal_o,
  output logic [`RV_XLEN-1:0]   pc_o
);
  import rv_pkg::*;

  logic                  valid_q;
  logic [31:0]           inst_q;
  logic [`RV_XLEN-1:0]   pc_q;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic                  funct7_b5;
  logic [`RV_XLEN-1:0]   imm_i;
  logic [`RV_XLEN-1:0]   imm_b;
  logic [`RV_XLEN-1:0]   imm_u;
  logic [`RV_XLEN-1:0]   imm_j;
  logic                  fwd1;
  logic                  fwd2;
  logic [`RV_XLEN-1:0]   src1;
  logic [`RV_XLEN-1:0]   src2;
  logic [`RV_XLEN-1:0]   jalr_sum;
  logic                  need_rs1;
  logic                  need_rs2;
  logic                  hazard;
  logic                  wen;

  function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic alu_op_e branch_func(input logic [2:0] f3);
    case (f3)
      3'b001:  return ALU_BNE;
      3'b100:  return ALU_BLT;
      3'b101:  return ALU_BGE;
      3'b110:  return ALU_BLTU;
      3'b111:  return ALU_BGEU;
      default: return ALU_BEQ;
    endcase
  endfunction

  // stage register, accepts when empty or when its content issues
  assign inst_ready_o = !valid_q || (id_valid_o && ex_ready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign opcode    = opcode_e'(inst_q[6:0]);
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];
  assign rd_o      = inst_q[7 +: `RV_REG_AW];
  assign rs1_o     = inst_q[15 +: `RV_REG_AW];
  assign rs2_o     = inst_q[20 +: `RV_REG_AW];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // tap of the alu stage wins over register file data
  assign fwd1 = fwd_valid_i && fwd_rd_i == rs1_o;
  assign fwd2 = fwd_valid_i && fwd_rd_i == rs2_o;
  assign src1 = fwd1 ? fwd_data_i : rdata1_i;
  assign src2 = fwd2 ? fwd_data_i : rdata2_i;

  assign need_rs1 = opcode inside {OP_JALR, OP_BRANCH, OP_IMM, OP_REG};
  assign need_rs2 = opcode inside {OP_BRANCH, OP_REG};
  assign hazard   = (need_rs1 && busy1_i && !fwd1) || (need_rs2 && busy2_i && !fwd2);

  assign id_valid_o   = valid_q && !hazard;
  assign issue_en_o   = id_valid_o && ex_ready_i && wen_o;
  assign issue_rd_o   = rd_o;
  assign pc_o         = pc_q;
  assign link_value_o = pc_q + `RV_XLEN'd4;
  assign jalr_sum     = src1 + imm_i;

  always_comb begin
    alu_op_o    = ALU_ADD;
    op1_o       = '0;
    op2_o       = '0;
    link_o      = 1'b0;
    br_target_o = '0;
    wen         = 1'b0;
    illegal_o   = 1'b0;
    case (opcode)
      OP_LUI: begin
        op2_o = imm_u;
        wen   = 1'b1;
      end
      OP_AUIPC: begin
        op1_o = pc_q;
        op2_o = imm_u;
        wen   = 1'b1;
      end
      OP_JAL: begin
        link_o      = 1'b1;
        br_target_o = pc_q + imm_j;
        wen         = 1'b1;
      end
      OP_JALR: begin
        link_o      = 1'b1;
        br_target_o = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        wen         = 1'b1;
      end
      OP_BRANCH: begin
        alu_op_o    = branch_func(funct3);
        op1_o       = src1;
        op2_o       = src2;
        br_target_o = pc_q + imm_b;
        // funct3 010 and 011 are not branches
        illegal_o   = funct3[2:1] == 2'b01;
      end
      OP_IMM: begin
        // funct7 bit only selects srai here
        alu_op_o = alu_func(funct3, funct3 == 3'b101 && funct7_b5);
        op1_o    = src1;
        op2_o    = imm_i;
        wen      = 1'b1;
      end
      OP_REG: begin
        alu_op_o = alu_func(funct3, funct7_b5);
        op1_o    = src1;
        op2_o    = src2;
        wen      = 1'b1;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

  assign wen_o = wen && rd_o != '0;

endmodule

`default_nettype wire

// ==== hdl/rv_exu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_exu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  id_valid_i,
  output logic                  ex_ready_o,
  input  rv_pkg::alu_op_e       alu_op_i,
  input  logic [`RV_XLEN-1:0]   op1_i,
  input  logic [`RV_XLEN-1:0]   op2_i,
  input  logic                  link_i,
  input  logic [`RV_XLEN-1:0]   link_value_i,
  input  logic [`RV_XLEN-1:0]   br_target_i,
  input  logic [`RV_REG_AW-1:0] rd_i,
  input  logic                  wen_i,
  input  logic                  illegal_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic                  fwd_valid_o,
  output logic [`RV_REG_AW-1:0] fwd_rd_o,
  output logic [`RV_XLEN-1:0]   fwd_data_o,
  output logic                  retire_valid_o,
  input  logic                  retire_ready_i,
  output logic [`RV_XLEN-1:0]   retire_pc_o,
  output logic [`RV_REG_AW-1:0] retire_rd_o,
  output logic                  retire_wen_o,
  output logic [`RV_XLEN-1:0]   retire_data_o,
  output logic                  retire_br_taken_o,
  output logic [`RV_XLEN-1:0]   retire_target_o,
  output logic                  retire_illegal_o,
  output logic                  wr_en_o,
  output logic [`RV_REG_AW-1:0] wr_rd_o,
  output logic [`RV_XLEN-1:0]   wr_data_o
);
  import rv_pkg::*;

  localparam int SHW = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0]   alu_res;
  logic                  cmp;
  logic                  a_valid;
  logic                  a_wen;
  logic                  a_taken;
  logic                  a_illegal;
  logic [`RV_REG_AW-1:0] a_rd;
  logic [`RV_XLEN-1:0]   a_data;
  logic [`RV_XLEN-1:0]   a_target;
  logic [`RV_XLEN-1:0]   a_pc;
  logic                  r_ready;

  always_comb begin
    alu_res = '0;
    cmp     = 1'b0;
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << op2_i[SHW-1:0];
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op1_i < op2_i};
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_SRL:  alu_res = op1_i >> op2_i[SHW-1:0];
      ALU_SRA:  alu_res = $signed(op1_i) >>> op2_i[SHW-1:0];
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      ALU_BEQ:  cmp = op1_i == op2_i;
      ALU_BNE:  cmp = op1_i != op2_i;
      ALU_BLT:  cmp = $signed(op1_i) < $signed(op2_i);
      ALU_BGE:  cmp = $signed(op1_i) >= $signed(op2_i);
      ALU_BLTU: cmp = op1_i < op2_i;
      default:  cmp = op1_i >= op2_i;
    endcase
  end

  // retire register takes new content when empty or draining
  assign r_ready    = !retire_valid_o || retire_ready_i;
  assign ex_ready_o = !a_valid || r_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      a_valid        <= 1'b0;
      retire_valid_o <= 1'b0;
    end else begin
      if (ex_ready_o) begin
        a_valid <= id_valid_i;
      end
      if (r_ready) begin
        retire_valid_o <= a_valid;
      end
    end
  end

  // alu stage register
  always_ff @(posedge clk) begin
    if (id_valid_i && ex_ready_o) begin
      a_data    <= link_i ? link_value_i : alu_res;
      a_taken   <= link_i || cmp;
      a_target  <= br_target_i;
      a_rd      <= rd_i;
      a_wen     <= wen_i;
      a_illegal <= illegal_i;
      a_pc      <= pc_i;
    end
  end

  // retire register
  always_ff @(posedge clk) begin
    if (a_valid && r_ready) begin
      retire_data_o     <= a_data;
      retire_br_taken_o <= a_taken;
      retire_target_o   <= a_target;
      retire_rd_o       <= a_rd;
      retire_wen_o      <= a_wen;
      retire_illegal_o  <= a_illegal;
      retire_pc_o       <= a_pc;
    end
  end

  assign fwd_valid_o = a_valid && a_wen;
  assign fwd_rd_o    = a_rd;
  assign fwd_data_o  = a_data;

  // a younger writer of the same rd in the alu stage supersedes this write,
  // which keeps that register busy until the younger one retires
  assign wr_en_o   = retire_valid_o && retire_ready_i && retire_wen_o &&
                     !(fwd_valid_o && a_rd == retire_rd_o);
  assign wr_rd_o   = retire_rd_o;
  assign wr_data_o = retire_data_o;

endmodule

`default_nettype wire

// ==== hdl/rv_issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_issue_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic                  retire_valid_o,
  input  logic                  retire_ready_i,
  output logic [`RV_XLEN-1:0]   retire_pc_o,
  output logic [`RV_REG_AW-1:0] retire_rd_o,
  output logic                  retire_wen_o,
  output logic [`RV_XLEN-1:0]   retire_data_o,
  output logic                  retire_br_taken_o,
  output logic [`RV_XLEN-1:0]   retire_target_o,
  output logic                  retire_illegal_o
);
  import rv_pkg::*;

  // register file lookups
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic                  busy1;
  logic                  busy2;
  logic                  issue_en;
  logic [`RV_REG_AW-1:0] issue_rd;
  logic                  wr_en;
  logic [`RV_REG_AW-1:0] wr_rd;
  logic [`RV_XLEN-1:0]   wr_data;

  // forwarding tap
  logic                  fwd_valid;
  logic [`RV_REG_AW-1:0] fwd_rd;
  logic [`RV_XLEN-1:0]   fwd_data;

  // decode to execute
  logic                  id_valid;
  logic                  ex_ready;
  alu_op_e               alu_op;
  logic [`RV_XLEN-1:0]   op1;
  logic [`RV_XLEN-1:0]   op2;
  logic                  link;
  logic [`RV_XLEN-1:0]   link_value;
  logic [`RV_XLEN-1:0]   br_target;
  logic [`RV_REG_AW-1:0] rd;
  logic                  wen;
  logic                  illegal;
  logic [`RV_XLEN-1:0]   pc;

  rv_regfile rv_regfile_i (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .busy1_o    (busy1),
    .busy2_o    (busy2),
    .issue_en_i (issue_en),
    .issue_rd_i (issue_rd),
    .wr_en_i    (wr_en),
    .wr_rd_i    (wr_rd),
    .wr_data_i  (wr_data)
  );

  rv_idu rv_idu_i (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .busy1_i      (busy1),
    .busy2_i      (busy2),
    .fwd_valid_i  (fwd_valid),
    .fwd_rd_i     (fwd_rd),
    .fwd_data_i   (fwd_data),
    .issue_en_o   (issue_en),
    .issue_rd_o   (issue_rd),
    .id_valid_o   (id_valid),
    .ex_ready_i   (ex_ready),
    .alu_op_o     (alu_op),
    .op1_o        (op1),
    .op2_o        (op2),
    .link_o       (link),
    .link_value_o (link_value),
    .br_target_o  (br_target),
    .rd_o         (rd),
    .wen_o        (wen),
    .illegal_o    (illegal),
    .pc_o         (pc)
  );

  rv_exu rv_exu_i (
    .clk               (clk),
    .rst               (rst),
    .id_valid_i        (id_valid),
    .ex_ready_o        (ex_ready),
    .alu_op_i          (alu_op),
    .op1_i             (op1),
    .op2_i             (op2),
    .link_i            (link),
    .link_value_i      (link_value),
    .br_target_i       (br_target),
    .rd_i              (rd),
    .wen_i             (wen),
    .illegal_i         (illegal),
    .pc_i              (pc),
    .fwd_valid_o       (fwd_valid),
    .fwd_rd_o          (fwd_rd),
    .fwd_data_o        (fwd_data),
    .retire_valid_o    (retire_valid_o),
    .retire_ready_i    (retire_ready_i),
    .retire_pc_o       (retire_pc_o),
    .retire_rd_o       (retire_rd_o),
    .retire_wen_o      (retire_wen_o),
    .retire_data_o     (retire_data_o),
    .retire_br_taken_o (retire_br_taken_o),
    .retire_target_o   (retire_target_o),
    .retire_illegal_o  (retire_illegal_o),
    .wr_en_o           (wr_en),
    .wr_rd_o           (wr_rd),
    .wr_data_o         (wr_data)
  );

endmodule

`default_nettype wire

// ==== sim/rv_issue_sva.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_issue_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  inst_ready_o,
  input logic                  retire_valid_o,
  input logic                  retire_ready_i,
  input logic [`RV_XLEN-1:0]   retire_pc_o,
  input logic [`RV_REG_AW-1:0] retire_rd_o,
  input logic                  retire_wen_o,
  input logic [`RV_XLEN-1:0]   retire_data_o,
  input logic                  retire_br_taken_o,
  input logic [`RV_XLEN-1:0]   retire_target_o,
  input logic                  retire_illegal_o
);

  // retire record held while the sink stalls
  property retire_stable;
    @(posedge clk) disable iff (rst)
      retire_valid_o && !retire_ready_i |=>
        retire_valid_o && $stable(retire_pc_o) && $stable(retire_rd_o) &&
        $stable(retire_wen_o) && $stable(retire_data_o) &&
        $stable(retire_br_taken_o) && $stable(retire_target_o) &&
        $stable(retire_illegal_o);
  endproperty

  property reset_state;
    @(posedge clk) $fell(rst) |-> inst_ready_o && !retire_valid_o;
  endproperty

  // no write to x0 and none from an illegal opcode
  property no_bad_write;
    @(posedge clk) disable iff (rst)
      retire_valid_o |-> !(retire_wen_o && (retire_rd_o == '0 || retire_illegal_o));
  endproperty

  a_retire_stable: assert property (retire_stable)
    else $error("retire fields changed while stalled");
  a_reset_state: assert property (reset_state)
    else $error("pipeline not empty after reset");
  a_no_bad_write: assert property (no_bad_write)
    else $error("retire write enable set for x0 or illegal opcode");

endmodule

bind rv_issue_top rv_issue_sva rv_issue_sva_i (.*);

`default_nettype wire

// ==== sim/rv_issue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_defines.svh"

module rv_issue_tb;

  localparam int REC_WORDS = 8;
  localparam int MAX_WORDS = 512;
  localparam int TIMEOUT_CYCLES = 1000;

  logic                  clk;
  logic                  rst;
  logic                  inst_valid_i;
  logic                  inst_ready_o;
  logic [31:0]           inst_i;
  logic [`RV_XLEN-1:0]   pc_i;
  logic                  retire_valid_o;
  logic                  retire_ready_i;
  logic [`RV_XLEN-1:0]   retire_pc_o;
  logic [`RV_REG_AW-1:0] retire_rd_o;
  logic                  retire_wen_o;
  logic [`RV_XLEN-1:0]   retire_data_o;
  logic                  retire_br_taken_o;
  logic [`RV_XLEN-1:0]   retire_target_o;
  logic                  retire_illegal_o;

  // word 0 holds the record count and the records follow
  logic [31:0] stim [MAX_WORDS];
  int          num_recs;
  int          retired;
  int          seed = 32'h1db9_032b;

  rv_issue_top rv_issue_top_i (
    .clk               (clk),
    .rst               (rst),
    .inst_valid_i      (inst_valid_i),
    .inst_ready_o      (inst_ready_o),
    .inst_i            (inst_i),
    .pc_i              (pc_i),
    .retire_valid_o    (retire_valid_o),
    .retire_ready_i    (retire_ready_i),
    .retire_pc_o       (retire_pc_o),
    .retire_rd_o       (retire_rd_o),
    .retire_wen_o      (retire_wen_o),
    .retire_data_o     (retire_data_o),
    .retire_br_taken_o (retire_br_taken_o),
    .retire_target_o   (retire_target_o),
    .retire_illegal_o  (retire_illegal_o)
  );

  always #5 clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  // data only matters for records that write a register
  task automatic compare_retire(input int idx);
    int base;
    base = 1 + idx * REC_WORDS;
    check("retire_pc_o", retire_pc_o, stim[base]);
    check("retire_rd_o", {28'b0, retire_rd_o}, stim[base+2]);
    check("retire_wen_o", {31'b0, retire_wen_o}, stim[base+3]);
    if (stim[base+3][0]) begin
      check("retire_data_o", retire_data_o, stim[base+4]);
    end
    check("retire_br_taken_o", {31'b0, retire_br_taken_o}, stim[base+5]);
    check("retire_target_o", retire_target_o, stim[base+6]);
    check("retire_illegal_o", {31'b0, retire_illegal_o}, stim[base+7]);
  endtask

  task automatic wait_accept();
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = inst_ready_o;
      cycles++;
      if (!done && cycles > TIMEOUT_CYCLES) begin
        stop_with_failure("instruction was never accepted by the DUT");
      end
    end
  endtask

  // random retire back-pressure on about one cycle in four
  always @(negedge clk) begin
    retire_ready_i = ($random(seed) & 3) != 0;
  end

  // retire monitor
  always @(posedge clk) begin
    if (rst) begin
      retired = 0;
    end else if (retire_valid_o && retire_ready_i) begin
      if (retired >= num_recs) begin
        stop_with_failure("DUT retired more instructions than were sent");
      end else begin
        compare_retire(retired);
        retired = retired + 1;
      end
    end
  end

  initial begin
    int idle;
    int seen;
    clk            = 1'b0;
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    pc_i           = '0;
    retire_ready_i = 1'b0;
    retired        = 0;
    $readmemh("sim/rv_issue_stim.txt", stim);
    num_recs = stim[0];
    if (num_recs <= 0 || 1 + num_recs * REC_WORDS > MAX_WORDS) begin
      stop_with_failure("stimulus file holds no usable record count");
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // driver presents the records in file order
    for (int r = 0; r < num_recs; r++) begin
      inst_valid_i = 1'b1;
      pc_i         = stim[1 + r * REC_WORDS];
      inst_i       = stim[2 + r * REC_WORDS];
      wait_accept();
      @(negedge clk);
    end
    inst_valid_i = 1'b0;

    // watchdog on the retire stream
    idle = 0;
    seen = retired;
    while (retired < num_recs) begin
      @(negedge clk);
      if (retired != seen) begin
        seen = retired;
        idle = 0;
      end else begin
        idle++;
      end
      if (idle > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("retire stream stopped after %0d of %0d records",
                                    retired, num_recs));
      end
    end

    // let any stray retire show up
    repeat (10) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/rv_issue_stim.txt ====
// word 0: record count; then one record per line, all hex:
// pc inst rd wen data taken target illegal
21
00000100 00500093 1 1 00000005 0 00000000 0
00000104 ffd00113 2 1 fffffffd 0 00000000 0
00000108 002081b3 3 1 00000002 0 00000000 0
0000010c 40118233 4 1 fffffffd 0 00000000 0
00000110 401252b3 5 1 ffffffff 0 00000000 0
00000114 40115313 6 1 fffffffe 0 00000000 0
00000118 01c15393 7 1 0000000f 0 00000000 0
0000011c 00409413 8 1 00000050 0 00000000 0
00000120 001124b3 9 1 00000001 0 00000000 0
00000124 00113533 a 1 00000000 0 00000000 0
00000128 0ff0c593 b 1 000000fa 0 00000000 0
0000012c 0085e633 c 1 000000fa 0 00000000 0
00000130 002676b3 d 1 000000f8 0 00000000 0
00000134 ffe12713 e 1 00000001 0 00000000 0
00000138 0060b793 f 1 00000001 0 00000000 0
0000013c 123450b7 1 1 12345000 0 00000000 0
00000140 00001117 2 1 00001140 0 00000000 0
00000144 010001ef 3 1 00000148 1 00000154 0
00000148 00310267 4 1 0000014c 1 00001142 0
0000014c 00108463 8 0 00000000 1 00000154 0
00000150 fe2098e3 1 0 00000000 1 00000140 0
00000154 00114263 4 0 00000000 1 00000158 0
00000158 00115263 4 0 00000000 0 0000015c 0
0000015c 0021e463 8 0 00000000 1 00000164 0
00000160 0042f663 c 0 00000000 1 0000016c 0
00000164 00708013 0 0 00000000 0 00000000 0
00000168 00100333 6 1 12345000 0 00000000 0
0000016c 00112023 0 0 00000000 0 00000000 1
00000170 0000a383 7 0 00000000 0 00000000 1
00000174 00138393 7 1 00000010 0 00000000 0
00000178 00138393 7 1 00000011 0 00000000 0
0000017c 00738433 8 1 00000022 0 00000000 0
00000180 00038493 9 1 00000011 0 00000000 0

// ==== flist.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_idu.sv
hdl/rv_exu.sv
hdl/rv_issue_top.sv
sim/rv_issue_sva.sv
sim/rv_issue_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -f flist.f --top-module rv_issue_tb -o rv_issue_sim
	./obj_dir/rv_issue_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
